// ==== src/audio_settings.svh ====
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// Number of DMA commands that software can queue.
`define AUDIO_CMDQ_DEPTH 4

// Number of stereo frames buffered ahead of playback.
`define AUDIO_FIFO_DEPTH 4

// Right shift after the volume multiply.
// With a 4-bit volume this gives a gain of value/16.
`define AUDIO_VOLUME_SHIFT 4

`endif

// ==== src/audio_pkg.sv ====
package audio_pkg;

	// One signed PCM sample.
	typedef logic signed [15:0] sample_t;

	// Left sample in the upper half, right sample in the lower half.
	typedef logic [31:0] frame_t;

	// Gain of value/16.
	typedef logic [3:0] volume_t;

	// Steps of the serialized volume multiply.
	typedef enum logic [1:0] {
		play_idle,
		play_mul_left,
		play_mul_right,
		play_emit
	} play_step_t;

endpackage

// ==== src/dma_pkg.sv ====
package dma_pkg;

	// Byte address on the Wishbone bus.
	typedef logic [31:0] bus_addr_t;

	// One Wishbone data word.
	typedef logic [31:0] bus_data_t;

	// Mono counts 16-bit samples, stereo counts frames.
	typedef logic [23:0] sample_count_t;

	typedef enum logic [2:0] {
		fetch_idle,
		fetch_wait_room,
		fetch_bus_read,
		fetch_push_low,
		fetch_push_high
	} fetch_state_t;

endpackage

// ==== src/dma_cmd_if.sv ====
`timescale 1ns/1ps

interface dma_cmd_if import dma_pkg::*; ();

	// Head command of the queue.
	logic          valid;
	logic          stereo;
	bus_addr_t     address;
	sample_count_t count;

	// One-cycle pulse after a replace.
	logic          flush;

	// Fetcher is ready for a new command.
	logic          take;

	modport queue (output valid, stereo, address, count, flush, input take);

	modport fetch (input valid, stereo, address, count, flush, output take);

endinterface

// ==== src/audio_cmd_queue.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module audio_cmd_queue import dma_pkg::*; #(
	parameter int depth = `AUDIO_CMDQ_DEPTH
) (
	input  logic          i_clock,
	input  logic          i_rst_n,
	input  logic          i_setup_valid,
	input  logic          i_setup_replace,
	input  logic          i_setup_stereo,
	input  bus_addr_t     i_setup_address,
	input  sample_count_t i_setup_count,
	dma_cmd_if.queue      cmd,
	output logic          o_pending
);

	localparam int ptr_w = $clog2(depth);
	localparam int used_w = $clog2(depth + 1);

	logic          stereo_mem [depth];
	bus_addr_t     address_mem [depth];
	sample_count_t count_mem [depth];

	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [used_w-1:0] used;
	logic              do_replace;
	logic              do_append;
	logic              do_pop;

	assign do_replace = i_setup_valid && i_setup_replace;
	assign do_append = i_setup_valid && !i_setup_replace && (used != used_w'(depth));
	assign do_pop = cmd.valid && cmd.take;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
			cmd.flush <= 1'b0;
		end else begin
			cmd.flush <= do_replace;
			if (do_replace) begin
				// New command becomes the only entry, in slot 0.
				wr_ptr <= ptr_w'(1);
				rd_ptr <= '0;
				used <= used_w'(1);
			end else begin
				if (do_append)
					wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
				if (do_pop)
					rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
				used <= used + used_w'(do_append) - used_w'(do_pop);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_replace || do_append) begin
			stereo_mem[do_replace ? '0 : wr_ptr] <= i_setup_stereo;
			address_mem[do_replace ? '0 : wr_ptr] <= i_setup_address;
			count_mem[do_replace ? '0 : wr_ptr] <= i_setup_count;
		end
	end

	assign cmd.valid = (used != '0);
	assign cmd.stereo = stereo_mem[rd_ptr];
	assign cmd.address = address_mem[rd_ptr];
	assign cmd.count = count_mem[rd_ptr];
	assign o_pending = (used != '0);

	a_used_bound: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		used <= used_w'(depth));

endmodule

// ==== src/audio_sample_fifo.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module audio_sample_fifo import audio_pkg::*; #(
	parameter int depth = `AUDIO_FIFO_DEPTH,
	parameter int free_w = $clog2(depth + 1)
) (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  logic              i_push,
	input  frame_t            i_frame,
	output logic [free_w-1:0] o_free,
	input  logic              i_pop,
	output frame_t            o_frame,
	output logic              o_empty
);

	localparam int ptr_w = $clog2(depth);

	frame_t            mem [depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [free_w-1:0] used;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (i_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			used <= used + free_w'(i_push) - free_w'(i_pop);
		end
	end

	// Read port is registered, data follows pop by one cycle.
	always_ff @(posedge i_clock) begin
		if (i_push)
			mem[wr_ptr] <= i_frame;
		if (i_pop)
			o_frame <= mem[rd_ptr];
	end

	assign o_empty = (used == '0);
	assign o_free = free_w'(depth) - used;

	a_no_overflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_push |-> (used != free_w'(depth)));

	a_no_underflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_pop |-> (used != '0));

endmodule

// ==== src/audio_dma_fetch.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module audio_dma_fetch import audio_pkg::*; import dma_pkg::*; #(
	parameter int free_w = $clog2(`AUDIO_FIFO_DEPTH + 1)
) (
	input  logic              i_clock,
	input  logic              i_rst_n,
	dma_cmd_if.fetch          cmd,
	output logic              o_wb_cyc,
	output logic              o_wb_stb,
	output bus_addr_t         o_wb_adr,
	input  logic              i_wb_ack,
	input  bus_data_t         i_wb_dat,
	input  logic [free_w-1:0] i_fifo_free,
	output logic              o_push,
	output frame_t            o_frame,
	output logic              o_active
);

	fetch_state_t  state;
	logic          stereo_q;
	bus_addr_t     addr_q;
	sample_count_t count_q;
	bus_data_t     word_q;
	logic          flush_q;
	logic          room;
	logic          stop;

	// Mono unpacks into two frames, stereo into one.
	assign room = stereo_q ? (i_fifo_free >= free_w'(1)) : (i_fifo_free >= free_w'(2));
	assign stop = flush_q || cmd.flush;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= fetch_idle;
			stereo_q <= 1'b0;
			addr_q <= '0;
			count_q <= '0;
			flush_q <= 1'b0;
		end else begin
			// A flush seen mid-command is held until the bus is idle.
			flush_q <= (state != fetch_idle) && stop;
			case (state)
				fetch_idle: begin
					if (cmd.valid) begin
						stereo_q <= cmd.stereo;
						addr_q <= cmd.address;
						count_q <= cmd.count;
						state <= fetch_wait_room;
					end
				end
				fetch_wait_room: begin
					if (stop || count_q == '0)
						state <= fetch_idle;
					else if (room)
						state <= fetch_bus_read;
				end
				fetch_bus_read: begin
					if (i_wb_ack) begin
						addr_q <= addr_q + bus_addr_t'(4);
						state <= fetch_push_low;
					end
				end
				fetch_push_low: begin
					count_q <= count_q - 1'b1;
					// Odd mono count skips the upper half of the last word.
					if (stereo_q || count_q == sample_count_t'(1))
						state <= fetch_wait_room;
					else
						state <= fetch_push_high;
				end
				fetch_push_high: begin
					count_q <= count_q - 1'b1;
					state <= fetch_wait_room;
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	// Bus word is captured in the acknowledge cycle.
	always_ff @(posedge i_clock) begin
		if (state == fetch_bus_read && i_wb_ack)
			word_q <= i_wb_dat;
	end

	always_comb begin
		if (stereo_q)
			o_frame = word_q;
		else if (state == fetch_push_high)
			o_frame = {word_q[31:16], word_q[31:16]};
		else
			o_frame = {word_q[15:0], word_q[15:0]};
	end

	assign o_wb_cyc = (state == fetch_bus_read);
	assign o_wb_stb = (state == fetch_bus_read);
	assign o_wb_adr = addr_q;
	assign o_push = (state == fetch_push_low) || (state == fetch_push_high);
	assign o_active = (state != fetch_idle);
	assign cmd.take = (state == fetch_idle);

	a_adr_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)));

endmodule

// ==== src/audio_playback.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module audio_playback import audio_pkg::*; (
	input  logic    i_clock,
	input  logic    i_rst_n,
	input  logic    i_sample_clock,
	input  volume_t i_volume,
	input  logic    i_fifo_empty,
	output logic    o_pop,
	input  frame_t  i_frame,
	output sample_t o_left,
	output sample_t o_right
);

	localparam int prod_w = $bits(sample_t) + $bits(volume_t) + 1;

	logic                     sclk_q;
	logic                     sclk_prev;
	logic                     change;
	play_step_t               step;
	sample_t                  mul_in;
	sample_t                  left_hold;
	sample_t                  scaled;
	logic signed [prod_w-1:0] prod;

	assign change = (sclk_q != sclk_prev);
	assign o_pop = change && !i_fifo_empty;

	// One multiplier, left half first and right half next.
	assign mul_in = (step == play_mul_left) ? sample_t'(i_frame[31:16]) :
		sample_t'(i_frame[15:0]);
	assign scaled = sample_t'(prod >>> `AUDIO_VOLUME_SHIFT);

	always_ff @(posedge i_clock) begin
		prod <= mul_in * $signed({1'b0, i_volume});
		if (step == play_mul_right)
			left_hold <= scaled;
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			sclk_q <= 1'b0;
			sclk_prev <= 1'b0;
			step <= play_idle;
			o_left <= '0;
			o_right <= '0;
		end else begin
			sclk_q <= i_sample_clock;
			sclk_prev <= sclk_q;
			// Popped frame is on i_frame in the mul_left step.
			if (o_pop) begin
				step <= play_mul_left;
			end else begin
				case (step)
					play_mul_left: step <= play_mul_right;
					play_mul_right: step <= play_emit;
					play_emit: begin
						o_left <= left_hold;
						o_right <= scaled;
						step <= play_idle;
					end
					default: step <= play_idle;
				endcase
			end
			// Underrun plays silence.
			if (change && i_fifo_empty) begin
				o_left <= '0;
				o_right <= '0;
			end
		end
	end

endmodule

// ==== src/audio_channel.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module audio_channel import audio_pkg::*; import dma_pkg::*; (
	input  logic          i_clock,
	input  logic          i_rst_n,
	input  logic          i_setup_valid,
	input  logic          i_setup_replace,
	input  logic          i_setup_stereo,
	input  bus_addr_t     i_setup_address,
	input  sample_count_t i_setup_count,
	output logic          o_wb_cyc,
	output logic          o_wb_stb,
	output bus_addr_t     o_wb_adr,
	input  logic          i_wb_ack,
	input  bus_data_t     i_wb_dat,
	input  volume_t       i_volume,
	input  logic          i_sample_clock,
	output sample_t       o_sample_left,
	output sample_t       o_sample_right,
	output logic          o_busy
);

	localparam int free_w = $clog2(`AUDIO_FIFO_DEPTH + 1);

	logic              cmd_pending;
	logic              fetch_active;
	logic              fifo_push;
	logic              fifo_pop;
	logic              fifo_empty;
	logic [free_w-1:0] fifo_free;
	frame_t            push_frame;
	frame_t            pop_frame;

	dma_cmd_if cmd_bus ();

	audio_cmd_queue audio_cmd_queue_inst (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_setup_valid(i_setup_valid),
		.i_setup_replace(i_setup_replace),
		.i_setup_stereo(i_setup_stereo),
		.i_setup_address(i_setup_address),
		.i_setup_count(i_setup_count),
		.cmd(cmd_bus),
		.o_pending(cmd_pending)
	);

	audio_dma_fetch #(.free_w(free_w)) audio_dma_fetch_inst (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.cmd(cmd_bus),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_adr(o_wb_adr),
		.i_wb_ack(i_wb_ack),
		.i_wb_dat(i_wb_dat),
		.i_fifo_free(fifo_free),
		.o_push(fifo_push),
		.o_frame(push_frame),
		.o_active(fetch_active)
	);

	audio_sample_fifo #(.free_w(free_w)) audio_sample_fifo_inst (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_push(fifo_push),
		.i_frame(push_frame),
		.o_free(fifo_free),
		.i_pop(fifo_pop),
		.o_frame(pop_frame),
		.o_empty(fifo_empty)
	);

	audio_playback audio_playback_inst (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_sample_clock(i_sample_clock),
		.i_volume(i_volume),
		.i_fifo_empty(fifo_empty),
		.o_pop(fifo_pop),
		.i_frame(pop_frame),
		.o_left(o_sample_left),
		.o_right(o_sample_right)
	);

	// Busy while commands wait or the fetcher still has samples.
	assign o_busy = cmd_pending || fetch_active;

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_rst_n
);

	// 8 ns period.
	initial begin
		o_clock = 1'b0;
		forever #4 o_clock = ~o_clock;
	end

	// Reset held low for the first 2 rising edges.
	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clock);
		o_rst_n <= 1'b1;
	end

endmodule

// ==== sim/audio_channel_tb.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module audio_channel_tb import audio_pkg::*; import dma_pkg::*; ();

	// Rising edges from the sample clock toggle to the output update.
	localparam int play_latency = 5;
	localparam int frame_gap = 3;
	// About 50 frames at 10 cycles each, with a wide margin.
	localparam int watchdog_cycles = 20000;
	localparam int mem_words = 512;

	logic          clock;
	logic          rst_n;
	logic          setup_valid;
	logic          setup_replace;
	logic          setup_stereo;
	bus_addr_t     setup_address;
	sample_count_t setup_count;
	logic          wb_cyc;
	logic          wb_stb;
	bus_addr_t     wb_adr;
	logic          wb_ack;
	bus_data_t     wb_dat;
	volume_t       volume;
	logic          sample_clock;
	sample_t       sample_left;
	sample_t       sample_right;
	logic          busy;

	bus_data_t mem [mem_words];
	int        ack_delay;
	bus_addr_t ack_addrs [$];
	bus_data_t ack_words [$];

	tb_clock_gen tb_clock_gen_inst (
		.o_clock(clock),
		.o_rst_n(rst_n)
	);

	audio_channel audio_channel_inst (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_setup_valid(setup_valid),
		.i_setup_replace(setup_replace),
		.i_setup_stereo(setup_stereo),
		.i_setup_address(setup_address),
		.i_setup_count(setup_count),
		.o_wb_cyc(wb_cyc),
		.o_wb_stb(wb_stb),
		.o_wb_adr(wb_adr),
		.i_wb_ack(wb_ack),
		.i_wb_dat(wb_dat),
		.i_volume(volume),
		.i_sample_clock(sample_clock),
		.o_sample_left(sample_left),
		.o_sample_right(sample_right),
		.o_busy(busy)
	);

	// Wishbone slave, word-addressed, acknowledge after a random delay.
	always @(posedge clock) begin
		wb_ack <= 1'b0;
		if (wb_cyc && wb_stb && !wb_ack) begin
			if (ack_delay == 0) begin
				wb_ack <= 1'b1;
				wb_dat <= mem[wb_adr[10:2]];
				ack_delay <= $urandom_range(3, 0);
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end
	end

	// Records every word that the DUT accepts.
	always @(posedge clock) begin
		if (wb_cyc && wb_stb && wb_ack) begin
			ack_addrs.push_back(wb_adr);
			ack_words.push_back(wb_dat);
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Watchdog timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped by the watchdog");
	end

	function automatic sample_t scale_sample(input sample_t s, input volume_t v);
		int prod;
		prod = int'(s) * int'(v);
		prod = prod >>> `AUDIO_VOLUME_SHIFT;
		return sample_t'(prod);
	endfunction

	function automatic bus_data_t word_at(input bus_addr_t addr);
		return mem[addr[10:2]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error in %s: expected %h, actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic send_command(input logic replace, input logic stereo, input bus_addr_t addr,
			input sample_count_t count);
		@(posedge clock);
		setup_valid <= 1'b1;
		setup_replace <= replace;
		setup_stereo <= stereo;
		setup_address <= addr;
		setup_count <= count;
	endtask

	task automatic end_command();
		@(posedge clock);
		setup_valid <= 1'b0;
	endtask

	task automatic load_random(input bus_addr_t base, input int n);
		for (int i = 0; i < n; i++)
			mem[base[10:2] + i] = $urandom();
	endtask

	task automatic clear_acks();
		ack_addrs.delete();
		ack_words.delete();
	endtask

	task automatic wait_for_acks(input int n);
		while (ack_addrs.size() < n)
			@(posedge clock);
	endtask

	// Toggle the sample clock and compare both outputs once they update.
	task automatic play_and_check(input string name, input frame_t frame, input volume_t vol);
		@(posedge clock);
		sample_clock <= ~sample_clock;
		volume <= vol;
		repeat (play_latency) @(posedge clock);
		@(negedge clock);
		check_value({name, " left"}, scale_sample(frame[31:16], vol), sample_left);
		check_value({name, " right"}, scale_sample(frame[15:0], vol), sample_right);
		repeat (frame_gap) @(posedge clock);
	endtask

	task automatic check_ack_addresses(input string name, input bus_addr_t first,
			input int first_n, input bus_addr_t second, input int total);
		bus_addr_t expected;
		check_value({name, " count"}, total, ack_addrs.size());
		for (int i = 0; i < total; i++) begin
			expected = (i < first_n) ? first + 4 * i : second + 4 * (i - first_n);
			check_value(name, expected, ack_addrs[i]);
		end
	endtask

	task automatic test_reset();
		wait (rst_n);
		@(negedge clock);
		check_value("reset cyc", 0, wb_cyc);
		check_value("reset stb", 0, wb_stb);
		check_value("reset busy", 0, busy);
		check_value("reset left", 0, sample_left);
		check_value("reset right", 0, sample_right);
	endtask

	task automatic test_stereo();
		load_random(32'h000, 6);
		clear_acks();
		send_command(1'b0, 1'b1, 32'h000, 6);
		end_command();
		@(negedge clock);
		check_value("stereo busy", 1, busy);
		wait_for_acks(`AUDIO_FIFO_DEPTH);
		for (int i = 0; i < 6; i++)
			play_and_check("stereo", word_at(32'h000 + 4 * i), 4'd15);
		check_ack_addresses("stereo address", 32'h000, 6, 32'h000, 6);
		@(negedge clock);
		check_value("stereo idle", 0, busy);
	endtask

	task automatic test_mono();
		bus_data_t word;
		sample_t   half;
		load_random(32'h080, 3);
		clear_acks();
		send_command(1'b0, 1'b0, 32'h080, 5);
		end_command();
		wait_for_acks(2);
		for (int i = 0; i < 5; i++) begin
			word = word_at(32'h080 + 4 * (i / 2));
			half = (i % 2) ? word[31:16] : word[15:0];
			play_and_check("mono", {half, half}, 4'd15);
		end
		// Nothing left after the fifth sample.
		play_and_check("mono end", 32'h0, 4'd15);
		check_ack_addresses("mono address", 32'h080, 3, 32'h080, 3);
	endtask

	task automatic test_volume();
		volume_t vol;
		load_random(32'h300, 8);
		mem[32'h300 >> 2] = 32'h8000_7fff;
		clear_acks();
		send_command(1'b0, 1'b1, 32'h300, 8);
		end_command();
		wait_for_acks(`AUDIO_FIFO_DEPTH);
		for (int i = 0; i < 8; i++) begin
			vol = $urandom_range(15, 0);
			play_and_check("volume", word_at(32'h300 + 4 * i), vol);
		end
	endtask

	task automatic test_append();
		load_random(32'h400, 3);
		load_random(32'h500, 4);
		clear_acks();
		send_command(1'b0, 1'b1, 32'h400, 3);
		send_command(1'b0, 1'b1, 32'h500, 4);
		end_command();
		wait_for_acks(`AUDIO_FIFO_DEPTH);
		for (int i = 0; i < 3; i++)
			play_and_check("append first", word_at(32'h400 + 4 * i), 4'd10);
		for (int i = 0; i < 4; i++)
			play_and_check("append second", word_at(32'h500 + 4 * i), 4'd10);
		check_ack_addresses("append address", 32'h400, 3, 32'h500, 7);
	endtask

	task automatic test_replace();
		int played;
		int b_seen;
		int a_cnt;
		play_and_check("underrun", 32'h0, 4'd9);
		load_random(32'h100, 40);
		load_random(32'h200, 4);
		clear_acks();
		send_command(1'b0, 1'b1, 32'h100, 40);
		end_command();
		wait_for_acks(`AUDIO_FIFO_DEPTH);
		played = 0;
		b_seen = 0;
		for (int i = 0; i < 2; i++) begin
			play_and_check("replace old", ack_words[played], 4'd12);
			played++;
		end
		send_command(1'b1, 1'b1, 32'h200, 4);
		end_command();
		// Frames play in the order their words were acknowledged.
		while (b_seen < 4) begin
			wait_for_acks(played + 1);
			if (ack_addrs[played] >= 32'h200)
				b_seen++;
			play_and_check("replace", ack_words[played], 4'd12);
			played++;
		end
		a_cnt = 0;
		foreach (ack_addrs[i])
			if (ack_addrs[i] < 32'h200)
				a_cnt++;
		check_value("replace cut short", 1, a_cnt < 40);
		check_ack_addresses("replace address", 32'h100, a_cnt, 32'h200, a_cnt + 4);
		play_and_check("replace end", 32'h0, 4'd12);
		check_value("replace idle", 0, busy);
	endtask

	initial begin
		void'($urandom(12821));
		setup_valid = 1'b0;
		setup_replace = 1'b0;
		setup_stereo = 1'b0;
		setup_address = '0;
		setup_count = '0;
		wb_ack = 1'b0;
		wb_dat = '0;
		volume = '0;
		sample_clock = 1'b0;
		ack_delay = 0;
		for (int i = 0; i < mem_words; i++)
			mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
		test_reset();
		test_stereo();
		test_mono();
		test_volume();
		test_append();
		test_replace();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+src
src/audio_pkg.sv
src/dma_pkg.sv
src/dma_cmd_if.sv
src/audio_cmd_queue.sv
src/audio_sample_fifo.sv
src/audio_dma_fetch.sv
src/audio_playback.sv
src/audio_channel.sv
sim/tb_clock_gen.sv
sim/audio_channel_tb.sv

// ==== Bender.yml ====
package:
  name: audio_channel

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/audio_pkg.sv
      - src/dma_pkg.sv
      - src/dma_cmd_if.sv
      - src/audio_cmd_queue.sv
      - src/audio_sample_fifo.sv
      - src/audio_dma_fetch.sv
      - src/audio_playback.sv
      - src/audio_channel.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/audio_channel_tb.sv
